//--- hdl/ahb_apb_defines.svh
// ------------------------------------------------
// AHB to APB bridge configuration
// Bus widths, APB slave count and the address map
// ------------------------------------------------

`ifndef AHB_APB_DEFINES_SVH
`define AHB_APB_DEFINES_SVH

// Bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Number of APB slaves behind the bridge
`define NUM_APB_SLAVES 4

// ------------------------------------------------
// Address map, inclusive ranges
// ------------------------------------------------
`define SLAVE0_BASE  32'h0000_0000
`define SLAVE0_LIMIT 32'h0000_0FFF

`define SLAVE1_BASE  32'h0000_1000
`define SLAVE1_LIMIT 32'h0000_1FFF

`define SLAVE2_BASE  32'h0000_2000
`define SLAVE2_LIMIT 32'h0000_2FFF

`define SLAVE3_BASE  32'h0000_3000
`define SLAVE3_LIMIT 32'h0000_3FFF

`endif

//--- hdl/ahb_apb_pkg.sv
// ------------------------------------------------
// AHB to APB bridge types
// Transfer structs, select and read data vectors,
// APB state encoding
// ------------------------------------------------

`include "ahb_apb_defines.svh"

package ahb_apb_pkg;

  // ------------------------------------------------
  // AHB side
  // ------------------------------------------------

  // Transfer as captured in the address phase
  typedef struct packed {
    logic [`AHB_ADDR_W-1:0] addr;
    logic                   write;
  } ahb_xfer_t;

  // ------------------------------------------------
  // APB side
  // ------------------------------------------------

  // Outputs shared by every APB slave
  typedef struct packed {
    logic [`AHB_ADDR_W-1:0] paddr;
    logic                   pwrite;
    logic [`AHB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // One bit per slave, at most one set
  typedef logic [`NUM_APB_SLAVES-1:0] sel_vec_t;

  // Read data of all slaves, slave 0 in the low word
  typedef logic [`NUM_APB_SLAVES-1:0][`AHB_DATA_W-1:0] rdata_vec_t;

  // APB master states, one-hot
  typedef enum logic [2:0] {
    IDLE   = 3'b001,
    SETUP  = 3'b010,
    ACCESS = 3'b100
  } apb_state_t;

endpackage

//--- hdl/ahb_slave_port.sv
// ------------------------------------------------
// AHB slave port of the bridge
// Accepts NONSEQ/SEQ transfers, holds hready low
// through the data phase and returns read data
// ------------------------------------------------

`timescale 1ns/1ps

`include "ahb_apb_defines.svh"

module ahb_slave_port (
  input  logic                   hclk4,
  input  logic                   hreset_n4,

  // AHB slave interface
  input  logic                   hsel,
  input  logic [1:0]             htrans,
  input  logic [`AHB_ADDR_W-1:0] haddr,
  input  logic                   hwrite,
  output logic                   hready,
  output logic [`AHB_DATA_W-1:0] hrdata,

  // Completion from the APB master
  input  logic                   xfer_done,
  input  logic [`AHB_DATA_W-1:0] rdata,

  // Captured transfer and phase tracking
  output ahb_apb_pkg::ahb_xfer_t xfer,
  output logic                   data_phase,
  output logic                   accept
);

  // htrans encodings that carry a transfer
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  logic valid_xfer;

  // IDLE and BUSY are ignored, as is anything without hsel
  assign valid_xfer = hsel &&
                      ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // Address phase is only taken while no transfer is pending
  assign accept = valid_xfer && hready;

  // ------------------------------------------------
  // Phase control and read data
  // ------------------------------------------------
  always_ff @(posedge hclk4 or negedge hreset_n4) begin
    if (!hreset_n4) begin
      hready     <= 1'b1;
      data_phase <= 1'b0;
      hrdata     <= '0;
    end else begin
      if (accept) begin
        // Stall the master until the APB side finishes
        hready     <= 1'b0;
        data_phase <= 1'b1;
      end else if (xfer_done) begin
        hready     <= 1'b1;
        data_phase <= 1'b0;
        hrdata     <= rdata;
      end
    end
  end

  // ------------------------------------------------
  // Address phase capture
  // ------------------------------------------------

  // Held stable for the whole data phase
  always_ff @(posedge hclk4) begin
    if (accept) begin
      xfer.addr  <= haddr;
      xfer.write <= hwrite;
    end
  end

endmodule

//--- hdl/apb_addr_decoder.sv
// ------------------------------------------------
// APB address decoder
// Registers a one-hot slave select from haddr at
// each accepted AHB address phase
// ------------------------------------------------

`timescale 1ns/1ps

`include "ahb_apb_defines.svh"

module apb_addr_decoder (
  input  logic                   hclk4,
  input  logic                   hreset_n4,
  input  logic [`AHB_ADDR_W-1:0] haddr,
  input  logic                   accept,
  output ahb_apb_pkg::sel_vec_t  slave_sel
);

  import ahb_apb_pkg::*;

  // Map as tables, slave 0 in the low entry
  localparam logic [`NUM_APB_SLAVES-1:0][`AHB_ADDR_W-1:0] BASE = {
    `SLAVE3_BASE,
    `SLAVE2_BASE,
    `SLAVE1_BASE,
    `SLAVE0_BASE
  };

  localparam logic [`NUM_APB_SLAVES-1:0][`AHB_ADDR_W-1:0] LIMIT = {
    `SLAVE3_LIMIT,
    `SLAVE2_LIMIT,
    `SLAVE1_LIMIT,
    `SLAVE0_LIMIT
  };

  sel_vec_t sel_next;

  // Range compare per slave
  // Unmapped address leaves every bit clear
  always_comb begin
    sel_next = '0;
    for (int i = 0; i < `NUM_APB_SLAVES; i++) begin
      if ((haddr >= BASE[i]) && (haddr <= LIMIT[i])) begin
        sel_next[i] = 1'b1;
      end
    end
  end

  // Select holds until the next accepted transfer
  always_ff @(posedge hclk4 or negedge hreset_n4) begin
    if (!hreset_n4) begin
      slave_sel <= '0;
    end else if (accept) begin
      slave_sel <= sel_next;
    end
  end

endmodule

//--- hdl/apb_master_fsm.sv
// ------------------------------------------------
// APB master state machine
// Runs one transfer through IDLE, SETUP and ACCESS
// and muxes pready and prdata of the selected slave
// ------------------------------------------------

`timescale 1ns/1ps

`include "ahb_apb_defines.svh"

module apb_master_fsm (
  input  logic                       hclk4,
  input  logic                       hreset_n4,

  // Transfer from the AHB side
  input  ahb_apb_pkg::ahb_xfer_t     xfer,
  input  logic                       data_phase,
  input  ahb_apb_pkg::sel_vec_t      slave_sel,
  input  logic [`AHB_DATA_W-1:0]     hwdata,

  // APB master interface
  output ahb_apb_pkg::apb_req_t      apb_req,
  output ahb_apb_pkg::sel_vec_t      psel,
  output logic                       penable,
  input  logic [`NUM_APB_SLAVES-1:0] pready,
  input  ahb_apb_pkg::rdata_vec_t    prdata,

  // Completion back to the AHB side
  output logic                       xfer_done,
  output logic [`AHB_DATA_W-1:0]     rdata
);

  import ahb_apb_pkg::*;

  apb_state_t state;
  logic       ready_mux;

  // ------------------------------------------------
  // Slave response mux
  // ------------------------------------------------

  // No slave selected means an unmapped address
  // which completes at once
  assign ready_mux = (psel == '0) || (|(psel & pready));

  // Zero when nothing is selected
  always_comb begin
    rdata = '0;
    for (int i = 0; i < `NUM_APB_SLAVES; i++) begin
      if (psel[i]) begin
        rdata = rdata | prdata[i];
      end
    end
  end

  // Single cycle pulse at the completing edge
  assign xfer_done = (state == ACCESS) && ready_mux;

  // ------------------------------------------------
  // State machine
  // ------------------------------------------------
  always_ff @(posedge hclk4 or negedge hreset_n4) begin
    if (!hreset_n4) begin
      state   <= IDLE;
      psel    <= '0;
      penable <= 1'b0;
      apb_req <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (data_phase) begin
            // hwdata is stable during the AHB data phase
            state          <= SETUP;
            psel           <= slave_sel;
            apb_req.paddr  <= xfer.addr;
            apb_req.pwrite <= xfer.write;
            apb_req.pwdata <= hwdata;
          end
        end

        SETUP: begin
          state   <= ACCESS;
          penable <= 1'b1;
        end

        ACCESS: begin
          // Wait states keep us here
          if (ready_mux) begin
            state   <= IDLE;
            psel    <= '0;
            penable <= 1'b0;
          end
        end

        default: begin
          state   <= IDLE;
          psel    <= '0;
          penable <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- hdl/ahb_apb_bridge.sv
// ------------------------------------------------
// AHB to APB bridge, top level
// AHB slave port, address decoder and APB master
// on a single clock
// ------------------------------------------------

`timescale 1ns/1ps

`include "ahb_apb_defines.svh"

module ahb_apb_bridge (
  input  logic                       hclk4,
  input  logic                       hreset_n4,

  // AHB slave side
  input  logic                       hsel,
  input  logic [`AHB_ADDR_W-1:0]     haddr,
  input  logic [1:0]                 htrans,
  input  logic                       hwrite,
  input  logic [`AHB_DATA_W-1:0]     hwdata,
  output logic                       hready,
  output logic [`AHB_DATA_W-1:0]     hrdata,

  // APB master side
  output ahb_apb_pkg::apb_req_t      apb_req,
  output ahb_apb_pkg::sel_vec_t      psel,
  output logic                       penable,
  input  logic [`NUM_APB_SLAVES-1:0] pready,
  input  ahb_apb_pkg::rdata_vec_t    prdata
);

  import ahb_apb_pkg::*;

  ahb_xfer_t                xfer;
  sel_vec_t                 slave_sel;
  logic                     data_phase;
  logic                     accept;
  logic                     xfer_done;
  logic [`AHB_DATA_W-1:0]   rdata;

  ahb_slave_port u_ahb_slave_port (
    .hclk4      (hclk4),
    .hreset_n4  (hreset_n4),
    .hsel       (hsel),
    .htrans     (htrans),
    .haddr      (haddr),
    .hwrite     (hwrite),
    .hready     (hready),
    .hrdata     (hrdata),
    .xfer_done  (xfer_done),
    .rdata      (rdata),
    .xfer       (xfer),
    .data_phase (data_phase),
    .accept     (accept)
  );

  // Decoded in the address phase, alongside the capture
  apb_addr_decoder u_apb_addr_decoder (
    .hclk4     (hclk4),
    .hreset_n4 (hreset_n4),
    .haddr     (haddr),
    .accept    (accept),
    .slave_sel (slave_sel)
  );

  apb_master_fsm u_apb_master_fsm (
    .hclk4      (hclk4),
    .hreset_n4  (hreset_n4),
    .xfer       (xfer),
    .data_phase (data_phase),
    .slave_sel  (slave_sel),
    .hwdata     (hwdata),
    .apb_req    (apb_req),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .prdata     (prdata),
    .xfer_done  (xfer_done),
    .rdata      (rdata)
  );

endmodule

//--- test/apb_slave_model.sv
// ------------------------------------------------
// Behavioral APB slave
// 16-word memory with a fixed number of wait states
// ------------------------------------------------

`timescale 1ns/1ps

`include "ahb_apb_defines.svh"

module apb_slave_model #(
  parameter int SLAVE_ID    = 0,
  parameter int WAIT_STATES = 0
) (
  input  logic                   hclk4,
  input  logic                   hreset_n4,

  // APB slave interface
  input  logic                   psel,
  input  logic                   penable,
  input  logic [`AHB_ADDR_W-1:0] paddr,
  input  logic                   pwrite,
  input  logic [`AHB_DATA_W-1:0] pwdata,
  output logic                   pready,
  output logic [`AHB_DATA_W-1:0] prdata
);

  logic [`AHB_DATA_W-1:0] mem [16];
  logic [3:0]             idx;
  int                     wait_cnt;

  // Word index inside the slave window
  assign idx = paddr[5:2];

  // Ready once the wait states of this ACCESS have passed
  assign pready = psel && penable && (wait_cnt == WAIT_STATES);

  // Only the selected slave drives read data
  assign prdata = (psel && !pwrite) ? mem[idx] : '0;

  // ------------------------------------------------
  // Wait counter and memory
  // ------------------------------------------------
  always_ff @(posedge hclk4 or negedge hreset_n4) begin
    if (!hreset_n4) begin
      wait_cnt <= 0;
      // Fill word carries the slave id and the word index
      for (int i = 0; i < 16; i++) begin
        mem[i] <= 32'hc000_0000 | (SLAVE_ID << 16) | i;
      end
    end else begin
      if (psel && penable && !pready) begin
        wait_cnt <= wait_cnt + 1;
      end else begin
        wait_cnt <= 0;
      end
      if (pready && pwrite) begin
        mem[idx] <= pwdata;
      end
    end
  end

endmodule

//--- test/tb_ahb_apb_bridge.sv
// ------------------------------------------------
// Testbench for the AHB to APB bridge
// Directed AHB transfers against four APB slave
// models with different wait states
// ------------------------------------------------

`timescale 1ns/1ps

`include "ahb_apb_defines.svh"

module tb_ahb_apb_bridge;

  import ahb_apb_pkg::*;

  localparam int         TIMEOUT_CYCLES = 40;
  localparam logic [1:0] HT_IDLE        = 2'b00;
  localparam logic [1:0] HT_BUSY        = 2'b01;
  localparam logic [1:0] HT_NONSEQ      = 2'b10;
  localparam int         WAIT_TABLE [`NUM_APB_SLAVES] = '{0, 0, 2, 5};

  logic                       hclk4;
  logic                       hreset_n4;
  logic                       hsel;
  logic [`AHB_ADDR_W-1:0]     haddr;
  logic [1:0]                 htrans;
  logic                       hwrite;
  logic [`AHB_DATA_W-1:0]     hwdata;
  logic                       hready;
  logic [`AHB_DATA_W-1:0]     hrdata;
  apb_req_t                   apb_req;
  sel_vec_t                   psel;
  logic                       penable;
  logic [`NUM_APB_SLAVES-1:0] pready;
  rdata_vec_t                 prdata;

  int                     errors;
  logic [`AHB_DATA_W-1:0] ref_mem [`NUM_APB_SLAVES][16];

  initial begin
    hclk4 = 1'b0;
    forever #2 hclk4 = ~hclk4;
  end

  ahb_apb_bridge UUT (
    .hclk4     (hclk4),
    .hreset_n4 (hreset_n4),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (hrdata),
    .apb_req   (apb_req),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .prdata    (prdata)
  );

  for (genvar g = 0; g < `NUM_APB_SLAVES; g++) begin : g_slave
    apb_slave_model #(
      .SLAVE_ID    (g),
      .WAIT_STATES (WAIT_TABLE[g])
    ) u_slave (
      .hclk4     (hclk4),
      .hreset_n4 (hreset_n4),
      .psel      (psel[g]),
      .penable   (penable),
      .paddr     (apb_req.paddr),
      .pwrite    (apb_req.pwrite),
      .pwdata    (apb_req.pwdata),
      .pready    (pready[g]),
      .prdata    (prdata[g])
    );
  end

  // ------------------------------------------------
  // Address map and reference helpers
  // ------------------------------------------------
  function automatic logic [31:0] slave_base(input int s);
    case (s)
      0:       return `SLAVE0_BASE;
      1:       return `SLAVE1_BASE;
      2:       return `SLAVE2_BASE;
      default: return `SLAVE3_BASE;
    endcase
  endfunction

  function automatic logic [31:0] slave_limit(input int s);
    case (s)
      0:       return `SLAVE0_LIMIT;
      1:       return `SLAVE1_LIMIT;
      2:       return `SLAVE2_LIMIT;
      default: return `SLAVE3_LIMIT;
    endcase
  endfunction

  // -1 for an unmapped address
  function automatic int slave_of(input logic [31:0] addr);
    int found;
    found = -1;
    for (int s = 0; s < `NUM_APB_SLAVES; s++) begin
      if ((addr >= slave_base(s)) && (addr <= slave_limit(s))) begin
        found = s;
      end
    end
    return found;
  endfunction

  function automatic sel_vec_t one_hot_sel(input int s);
    if (s < 0) begin
      return '0;
    end
    return sel_vec_t'(1) << s;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // ------------------------------------------------
  // AHB driver
  // ------------------------------------------------

  // One transfer with the APB side checked at every stalled cycle
  task automatic ahb_xfer(input logic write, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int low_cycles);
    sel_vec_t exp_sel;
    int       cyc;
    logic     done;
    exp_sel = one_hot_sel(slave_of(addr));
    cyc     = 0;
    done    = 1'b0;
    rdata   = '0;
    @(posedge hclk4);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= HT_NONSEQ;
    hwrite <= write;
    @(posedge hclk4);
    // Address phase taken and data phase begins
    hsel   <= 1'b0;
    htrans <= HT_IDLE;
    hwdata <= wdata;
    while (!done && (cyc < TIMEOUT_CYCLES)) begin
      @(negedge hclk4);
      if (hready) begin
        done = 1'b1;
      end else begin
        cyc++;
        // SETUP from the second stalled cycle and ACCESS from the third
        check(psel, (cyc >= 2) ? exp_sel : '0, $sformatf("psel, addr %h", addr));
        check(penable, cyc >= 3, $sformatf("penable, addr %h", addr));
        if (cyc >= 2) begin
          check(apb_req.paddr, addr, "paddr");
          check(apb_req.pwrite, write, "pwrite");
          if (write) begin
            check(apb_req.pwdata, wdata, "pwdata");
          end
        end
      end
    end
    low_cycles = cyc;
    if (!done) begin
      $display("Timeout: hready stayed low for %0d cycles, addr %h", cyc, addr);
      $display("TEST FAILED");
      $finish;
    end else begin
      check(psel, '0, "psel after completion");
      check(penable, 1'b0, "penable after completion");
      rdata = hrdata;
    end
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                           output int low_cycles);
    logic [31:0] unused_rd;
    ahb_xfer(1'b1, addr, data, unused_rd, low_cycles);
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data,
                          output int low_cycles);
    ahb_xfer(1'b0, addr, $urandom, data, low_cycles);
  endtask

  // ------------------------------------------------
  // Directed tests
  // ------------------------------------------------
  task automatic test_reset_state();
    check(hready, 1'b1, "hready after reset");
    check(psel, '0, "psel after reset");
    check(penable, 1'b0, "penable after reset");
    check(hrdata, '0, "hrdata after reset");
    check(apb_req.paddr, '0, "paddr after reset");
    check(apb_req.pwrite, 1'b0, "pwrite after reset");
    check(apb_req.pwdata, '0, "pwdata after reset");
  endtask

  // Write and read back per slave with its stall length
  task automatic test_write_read();
    int          idx;
    int          low;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    for (int s = 0; s < `NUM_APB_SLAVES; s++) begin
      idx  = $urandom % 16;
      addr = slave_base(s) + idx * 4;
      data = $urandom;
      ahb_write(addr, data, low);
      check(low, 3 + WAIT_TABLE[s], $sformatf("write stall cycles, slave %0d", s));
      ref_mem[s][idx] = data;
      ahb_read(addr, rd, low);
      check(rd, ref_mem[s][idx], $sformatf("read back, addr %h", addr));
      check(low, 3 + WAIT_TABLE[s], $sformatf("read stall cycles, slave %0d", s));
      // Neighbouring word still holds its fill value
      addr = slave_base(s) + ((idx + 1) % 16) * 4;
      ahb_read(addr, rd, low);
      check(rd, ref_mem[s][(idx + 1) % 16], $sformatf("untouched word, addr %h", addr));
    end
  endtask

  task automatic test_unmapped();
    int          low;
    logic [31:0] rd;
    logic [31:0] data;
    ahb_read(32'h0000_8000, rd, low);
    check(rd, '0, "unmapped read data");
    check(low, 3, "unmapped stall cycles");
    data = $urandom;
    ahb_write(slave_base(0) + 32'h3c, data, low);
    ref_mem[0][15] = data;
    ahb_read(slave_base(0) + 32'h3c, rd, low);
    check(rd, ref_mem[0][15], "slave 0 after unmapped access");
  endtask

  // Bus held in a non-transfer state for 10 cycles
  task automatic watch_idle(input logic sel, input logic [1:0] trans, input string what);
    @(posedge hclk4);
    hsel   <= sel;
    haddr  <= slave_base(1);
    htrans <= trans;
    hwrite <= 1'b1;
    repeat (10) begin
      @(negedge hclk4);
      check(hready, 1'b1, {"hready, ", what});
      check(psel, '0, {"psel, ", what});
    end
    @(posedge hclk4);
    hsel   <= 1'b0;
    htrans <= HT_IDLE;
  endtask

  task automatic test_ignored();
    watch_idle(1'b0, HT_NONSEQ, "hsel low");
    watch_idle(1'b1, HT_IDLE, "htrans IDLE");
    watch_idle(1'b1, HT_BUSY, "htrans BUSY");
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    errors    = 0;
    void'($urandom(32'hd8da));
    hreset_n4 = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = HT_IDLE;
    hwrite    = 1'b0;
    hwdata    = '0;
    for (int s = 0; s < `NUM_APB_SLAVES; s++) begin
      for (int i = 0; i < 16; i++) begin
        ref_mem[s][i] = 32'hc000_0000 | (s << 16) | i;
      end
    end
    repeat (3) @(posedge hclk4);
    hreset_n4 <= 1'b1;
    @(negedge hclk4);
    test_reset_state();
    test_write_read();
    test_unmapped();
    test_ignored();
    repeat (2) @(posedge hclk4);
    $display("Checks finished with %0d error(s)", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- ahb_apb_bridge.f
+incdir+hdl
hdl/ahb_apb_pkg.sv
hdl/ahb_slave_port.sv
hdl/apb_addr_decoder.sv
hdl/apb_master_fsm.sv
hdl/ahb_apb_bridge.sv
test/apb_slave_model.sv
test/tb_ahb_apb_bridge.sv
